// ==== design/plot_macros.svh ====
`ifndef PLOT_MACROS_SVH
`define PLOT_MACROS_SVH

// ******************************
// Signed Q12.8 number format
// ******************************
`define PLOT_INT_W        12
`define PLOT_FRAC_W       8
`define PLOT_NUM_W        20

// Token memory and value stack
`define PLOT_QUEUE_DEPTH  32
`define PLOT_QUEUE_AW     5
`define PLOT_STACK_DEPTH  16

// ******************************
// Screen geometry
// ******************************
`define PLOT_HOR          640
`define PLOT_VER          480
`define PLOT_SCALE        20    // Screen pixels per world unit

`define PLOT_TOKEN_W      21    // is_op flag above one number word

`endif

// ==== design/plot_pkg.sv ====
`include "plot_macros.svh"

package plot_pkg;

    typedef enum logic [2:0] {
        OP_ADD   = 3'd0,
        OP_SUB   = 3'd1,
        OP_MUL   = 3'd2,
        OP_DIV   = 3'd3,
        OP_VAR_X = 3'd6
    } opcode_e;

    // The same payload word is a literal or an operator code
    typedef union packed {
        logic signed [`PLOT_NUM_W-1:0] value;
        struct packed {
            logic [`PLOT_NUM_W-4:0] pad;
            opcode_e                op;
        } oper;
    } token_payload_u;

    // is_op selects which view of the payload applies
    typedef struct packed {
        logic           is_op;
        token_payload_u payload;
    } token_t;

endpackage

// ==== design/alu_if.sv ====
`timescale 1ns/1ps
`include "plot_macros.svh"

interface alu_if;

    logic                   start;
    plot_pkg::opcode_e      op;
    logic [`PLOT_NUM_W-1:0] a;
    logic [`PLOT_NUM_W-1:0] b;
    logic                   done;
    logic [`PLOT_NUM_W-1:0] result;    // Valid with done
    logic                   div_zero;  // Valid with done

    // op, a and b are held by the client until done
    modport client (
        output start, op, a, b,
        input  done, result, div_zero
    );

    modport server (
        input  start, op, a, b,
        output done, result, div_zero
    );

endinterface

// ==== design/token_if.sv ====
`timescale 1ns/1ps
`include "plot_macros.svh"

interface token_if;

    logic                      get;
    logic [`PLOT_QUEUE_AW-1:0] index;
    logic                      ready;  // One cycle after get
    plot_pkg::token_t          token;

    modport reader (
        output get, index,
        input  ready, token
    );

    modport memory (
        input  get, index,
        output ready, token
    );

endinterface

// ==== design/fixed_point_alu.sv ====
`timescale 1ns/1ps
`include "plot_macros.svh"

module fixed_point_alu (
    input logic   clk,
    input logic   rst,
    alu_if.server alu
);

    localparam int NUM_W  = `PLOT_NUM_W;
    localparam int FRAC_W = `PLOT_FRAC_W;
    localparam int DIV_W  = `PLOT_NUM_W + `PLOT_FRAC_W;  // Dividend after the pre-shift
    localparam int CNT_W  = $clog2(DIV_W + 1);

    logic signed [2*NUM_W-1:0] product;
    logic [NUM_W-1:0]          mag_a;
    logic [NUM_W-1:0]          mag_b;
    logic [NUM_W-1:0]          div_den;
    logic [NUM_W-1:0]          div_rem;
    logic [NUM_W-1:0]          rem_next;
    logic [NUM_W:0]            rem_shift;
    logic [NUM_W:0]            rem_diff;
    logic [DIV_W-1:0]          div_quo;
    logic [DIV_W-1:0]          quo_next;
    logic [DIV_W-1:0]          quo_signed;
    logic [CNT_W-1:0]          div_cnt;
    logic                      div_busy;
    logic                      div_neg;
    logic                      take;

    assign product = $signed(alu.a) * $signed(alu.b);
    assign mag_a   = alu.a[NUM_W-1] ? -alu.a : alu.a;
    assign mag_b   = alu.b[NUM_W-1] ? -alu.b : alu.b;

    // ******************************
    // One restoring step per cycle
    // ******************************
    assign rem_shift  = {div_rem, div_quo[DIV_W-1]};
    assign rem_diff   = rem_shift - {1'b0, div_den};
    assign take       = rem_shift >= {1'b0, div_den};
    assign rem_next   = take ? rem_diff[NUM_W-1:0] : rem_shift[NUM_W-1:0];
    assign quo_next   = {div_quo[DIV_W-2:0], take};
    assign quo_signed = div_neg ? -quo_next : quo_next;  // Truncates toward zero

    always_ff @(posedge clk) begin
        if (rst) begin
            div_busy     <= 1'b0;
            div_cnt      <= '0;
            alu.done     <= 1'b0;
            alu.div_zero <= 1'b0;
        end else begin
            alu.done     <= 1'b0;
            alu.div_zero <= 1'b0;
            if (div_busy) begin
                div_cnt <= div_cnt - 1'b1;
                if (div_cnt == CNT_W'(1)) begin
                    div_busy <= 1'b0;
                    alu.done <= 1'b1;
                end
            end else if (alu.start) begin
                if (alu.op == plot_pkg::OP_DIV && alu.b != '0) begin
                    div_busy <= 1'b1;
                    div_cnt  <= CNT_W'(DIV_W);
                end else begin
                    alu.done     <= 1'b1;  // Zero divisor short-cuts here
                    alu.div_zero <= (alu.op == plot_pkg::OP_DIV);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div_busy) begin
            div_rem <= rem_next;
            div_quo <= quo_next;
            if (div_cnt == CNT_W'(1))
                alu.result <= quo_signed[NUM_W-1:0];
        end else if (alu.start) begin
            div_rem <= '0;
            div_quo <= {mag_a, {FRAC_W{1'b0}}};
            div_den <= mag_b;
            div_neg <= alu.a[NUM_W-1] ^ alu.b[NUM_W-1];
            case (alu.op)
                plot_pkg::OP_ADD: alu.result <= alu.a + alu.b;
                plot_pkg::OP_SUB: alu.result <= alu.a - alu.b;
                plot_pkg::OP_MUL: alu.result <= product[NUM_W+FRAC_W-1:FRAC_W];
                default:          alu.result <= '0;
            endcase
        end
    end

endmodule

// ==== design/token_queue.sv ====
`timescale 1ns/1ps
`include "plot_macros.svh"

module token_queue (
    input logic                      clk,
    input logic                      rst,
    input logic                      load_en,
    input logic [`PLOT_QUEUE_AW-1:0] load_addr,
    input plot_pkg::token_t          load_token,
    token_if.memory                  rd
);

    plot_pkg::token_t mem [`PLOT_QUEUE_DEPTH];

    // Host writes and machine reads share one clock
    always_ff @(posedge clk) begin
        if (load_en)
            mem[load_addr] <= load_token;
        if (rd.get)
            rd.token <= mem[rd.index];
    end

    always_ff @(posedge clk) begin
        if (rst)
            rd.ready <= 1'b0;
        else
            rd.ready <= rd.get;  // Token is valid alongside this pulse
    end

endmodule

// ==== design/stack_machine.sv ====
`timescale 1ns/1ps
`include "plot_macros.svh"

module stack_machine (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic [`PLOT_INT_W-1:0]  x_pixel,
    input  logic [`PLOT_QUEUE_AW:0] expr_len,
    output logic                    ready,
    output logic                    done,
    output logic                    fault,
    output logic [`PLOT_INT_W-1:0]  y_pixel,
    token_if.reader                 rd,
    alu_if.client                   alu
);

    localparam int NUM_W  = `PLOT_NUM_W;
    localparam int FRAC_W = `PLOT_FRAC_W;
    localparam int SP_W   = $clog2(`PLOT_STACK_DEPTH + 1);
    localparam int STK_AW = $clog2(`PLOT_STACK_DEPTH);

    // Transform constants in Q12.8
    localparam logic [NUM_W-1:0] HALF_HOR = (`PLOT_HOR / 2) << FRAC_W;
    localparam logic [NUM_W-1:0] HALF_VER = (`PLOT_VER / 2) << FRAC_W;
    localparam logic [NUM_W-1:0] SCALE    = `PLOT_SCALE << FRAC_W;

    typedef enum logic [3:0] {
        S_IDLE,
        S_X_SUB,
        S_X_DIV,
        S_FETCH,
        S_TOKEN,
        S_OPERATE,
        S_CHECK,
        S_Y_DIV,
        S_Y_ADD,
        S_FAULT
    } state_e;

    state_e                  state;
    logic [NUM_W-1:0]        stack [`PLOT_STACK_DEPTH];
    logic [SP_W-1:0]         sp;       // Number of entries in use
    logic [`PLOT_QUEUE_AW:0] tok_cnt;
    logic [`PLOT_QUEUE_AW:0] len;
    logic [NUM_W-1:0]        x_val;
    logic [NUM_W-1:0]        top;
    logic [NUM_W-1:0]        below;

    assign rd.index = tok_cnt[`PLOT_QUEUE_AW-1:0];
    assign top      = stack[STK_AW'(sp - 1'b1)];
    assign below    = stack[STK_AW'(sp - 2'd2)];

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            ready     <= 1'b1;
            done      <= 1'b0;
            fault     <= 1'b0;
            y_pixel   <= '0;
            alu.start <= 1'b0;
            rd.get    <= 1'b0;
            sp        <= '0;
            tok_cnt   <= '0;
        end else begin
            done      <= 1'b0;
            alu.start <= 1'b0;
            rd.get    <= 1'b0;
            case (state)
                S_IDLE: if (start) begin
                    ready     <= 1'b0;
                    sp        <= '0;
                    tok_cnt   <= '0;
                    len       <= expr_len;
                    alu.start <= 1'b1;
                    alu.op    <= plot_pkg::OP_SUB;
                    alu.a     <= {x_pixel, {FRAC_W{1'b0}}};
                    alu.b     <= HALF_HOR;
                    state     <= S_X_SUB;
                end
                S_X_SUB: if (alu.done) begin
                    alu.start <= 1'b1;
                    alu.op    <= plot_pkg::OP_DIV;
                    alu.a     <= alu.result;
                    alu.b     <= SCALE;
                    state     <= S_X_DIV;
                end
                S_X_DIV: if (alu.done) begin
                    x_val <= alu.result;
                    state <= S_FETCH;
                end
                // ******************************
                // Postfix program
                // ******************************
                S_FETCH: begin
                    if (tok_cnt == len) begin
                        state <= S_CHECK;
                    end else begin
                        rd.get <= 1'b1;
                        state  <= S_TOKEN;
                    end
                end
                S_TOKEN: if (rd.ready) begin
                    tok_cnt <= tok_cnt + 1'b1;
                    if (rd.token.is_op && rd.token.payload.oper.op != plot_pkg::OP_VAR_X) begin
                        if (sp < SP_W'(2)) begin
                            state <= S_FAULT;  // Underflow
                        end else begin
                            alu.start <= 1'b1;
                            alu.op    <= rd.token.payload.oper.op;
                            alu.a     <= below;
                            alu.b     <= top;
                            state     <= S_OPERATE;
                        end
                    end else if (sp == SP_W'(`PLOT_STACK_DEPTH)) begin
                        state <= S_FAULT;
                    end else begin
                        stack[STK_AW'(sp)] <= rd.token.is_op ? x_val : rd.token.payload.value;
                        sp    <= sp + 1'b1;
                        state <= S_FETCH;
                    end
                end
                S_OPERATE: if (alu.done) begin
                    if (alu.div_zero) begin
                        state <= S_FAULT;
                    end else begin
                        stack[STK_AW'(sp - 2'd2)] <= alu.result;  // Two pops and a push
                        sp    <= sp - 1'b1;
                        state <= S_FETCH;
                    end
                end
                S_CHECK: begin
                    if (sp != SP_W'(1)) begin
                        state <= S_FAULT;
                    end else begin
                        alu.start <= 1'b1;
                        alu.op    <= plot_pkg::OP_DIV;
                        alu.a     <= stack[0];
                        alu.b     <= SCALE;
                        state     <= S_Y_DIV;
                    end
                end
                S_Y_DIV: if (alu.done) begin
                    alu.start <= 1'b1;
                    alu.op    <= plot_pkg::OP_ADD;
                    alu.a     <= alu.result;
                    alu.b     <= HALF_VER;
                    state     <= S_Y_ADD;
                end
                S_Y_ADD: if (alu.done) begin
                    y_pixel <= alu.result[NUM_W-1:FRAC_W];  // Integer part only
                    fault   <= 1'b0;
                    done    <= 1'b1;
                    ready   <= 1'b1;
                    state   <= S_IDLE;
                end
                S_FAULT: begin
                    y_pixel <= '0;
                    fault   <= 1'b1;
                    done    <= 1'b1;
                    ready   <= 1'b1;
                    state   <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// ==== design/plot_evaluator.sv ====
`timescale 1ns/1ps
`include "plot_macros.svh"

module plot_evaluator (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      load_en,
    input  logic [`PLOT_QUEUE_AW-1:0] load_addr,
    input  logic [`PLOT_TOKEN_W-1:0]  load_token,
    input  logic [`PLOT_QUEUE_AW:0]   expr_len,
    input  logic                      start,
    input  logic [`PLOT_INT_W-1:0]    x_pixel,
    output logic                      ready,
    output logic                      done,
    output logic                      fault,
    output logic [`PLOT_INT_W-1:0]    y_pixel
);

    alu_if   alu_bus ();
    token_if tok_bus ();

    token_queue token_queue_i (
        .clk        (clk),
        .rst        (rst),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_token (plot_pkg::token_t'(load_token)),
        .rd         (tok_bus.memory)
    );

    stack_machine stack_machine_i (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .x_pixel  (x_pixel),
        .expr_len (expr_len),
        .ready    (ready),
        .done     (done),
        .fault    (fault),
        .y_pixel  (y_pixel),
        .rd       (tok_bus.reader),
        .alu      (alu_bus.client)
    );

    fixed_point_alu fixed_point_alu_i (
        .clk (clk),
        .rst (rst),
        .alu (alu_bus.server)
    );

endmodule

// ==== tests/plot_evaluator_asserts.sv ====
`timescale 1ns/1ps

module plot_evaluator_asserts (
    input logic clk,
    input logic rst,
    input logic start,
    input logic ready,
    input logic done,
    input logic alu_start,
    input logic alu_done
);

    logic alu_busy;  // An ALU request is outstanding
    logic in_eval;

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_busy <= 1'b0;
            in_eval  <= 1'b0;
        end else begin
            if (alu_done)
                alu_busy <= 1'b0;
            if (alu_start)
                alu_busy <= 1'b1;
            if (done)
                in_eval <= 1'b0;
            if (start && ready)
                in_eval <= 1'b1;
        end
    end

    alu_one_request: assert property (@(posedge clk) disable iff (rst) alu_start |-> !alu_busy)
        else $error("ALU start issued while a request is outstanding");

    done_single_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done stayed high for more than one cycle");

    ready_low_in_eval: assert property (@(posedge clk) disable iff (rst)
                                        (in_eval && !done) |-> !ready)
        else $error("ready high while an evaluation is running");

endmodule

bind stack_machine plot_evaluator_asserts asserts_i (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .ready     (ready),
    .done      (done),
    .alu_start (alu.start),
    .alu_done  (alu.done)
);

// ==== tests/plot_evaluator_checker.sv ====
`timescale 1ns/1ps
`include "plot_macros.svh"

module plot_evaluator_checker (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      load_en,
    input  logic [`PLOT_QUEUE_AW-1:0] load_addr,
    input  logic [`PLOT_TOKEN_W-1:0]  load_token,
    input  logic [`PLOT_QUEUE_AW:0]   expr_len,
    input  logic                      start,
    input  logic [`PLOT_INT_W-1:0]    x_pixel,
    input  logic                      exp_fault,
    input  logic                      ready,
    input  logic                      done,
    input  logic                      fault,
    input  logic [`PLOT_INT_W-1:0]    y_pixel,
    output int                        errors,
    output int                        checks
);

    localparam int NUM_W  = `PLOT_NUM_W;
    localparam int FRAC_W = `PLOT_FRAC_W;
    localparam logic [NUM_W-1:0] HALF_HOR = NUM_W'((`PLOT_HOR / 2) << FRAC_W);
    localparam logic [NUM_W-1:0] HALF_VER = NUM_W'((`PLOT_VER / 2) << FRAC_W);
    localparam logic [NUM_W-1:0] SCALE    = NUM_W'(`PLOT_SCALE << FRAC_W);

    plot_pkg::token_t       mem [`PLOT_QUEUE_DEPTH];  // Shadow of the token memory
    logic [`PLOT_INT_W-1:0] model_y;
    bit                     model_fault;
    bit                     table_fault;
    int                     pending;
    bit                     was_rst;
    bit                     after_start;
    logic [`PLOT_INT_W-1:0] held_y;      // Outputs of the last done
    bit                     held_fault;

    initial begin
        errors  = 0;
        checks  = 0;
        pending = 0;
        was_rst = 0;
    end

    task automatic report(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errors++;
    endtask

    // Q12.8 arithmetic where a is the entry below the top
    function automatic logic [NUM_W-1:0] apply(input plot_pkg::opcode_e op,
                                               input logic [NUM_W-1:0] a,
                                               input logic [NUM_W-1:0] b);
        logic signed [NUM_W-1:0] sa;
        logic signed [NUM_W-1:0] sb;
        longint                  p;
        sa = a;
        sb = b;
        case (op)
            plot_pkg::OP_ADD: return a + b;
            plot_pkg::OP_SUB: return a - b;
            plot_pkg::OP_MUL: begin
                p = longint'(sa) * longint'(sb);
                return NUM_W'(p >>> FRAC_W);
            end
            plot_pkg::OP_DIV: begin
                p = (longint'(sa) * (1 << FRAC_W)) / longint'(sb);  // Truncates toward zero
                return NUM_W'(p);
            end
            default: return '0;
        endcase
    endfunction

    task automatic run_model(input logic [`PLOT_INT_W-1:0] xp, input int len);
        logic [NUM_W-1:0] stk [`PLOT_STACK_DEPTH];
        logic [NUM_W-1:0] xw;
        logic [NUM_W-1:0] r;
        plot_pkg::token_t t;
        int               depth;
        int               i;
        bit               bad;
        xw    = apply(plot_pkg::OP_SUB, {xp, {FRAC_W{1'b0}}}, HALF_HOR);
        xw    = apply(plot_pkg::OP_DIV, xw, SCALE);
        depth = 0;
        bad   = 0;
        for (i = 0; i < len && !bad; i++) begin
            t = mem[i];
            if (t.is_op && t.payload.oper.op != plot_pkg::OP_VAR_X) begin
                if (depth < 2)
                    bad = 1;
                else if (t.payload.oper.op == plot_pkg::OP_DIV && stk[depth-1] == '0)
                    bad = 1;
                else begin
                    stk[depth-2] = apply(t.payload.oper.op, stk[depth-2], stk[depth-1]);
                    depth--;
                end
            end else if (depth == `PLOT_STACK_DEPTH) begin
                bad = 1;
            end else begin
                stk[depth] = t.is_op ? xw : t.payload.value;
                depth++;
            end
        end
        if (depth != 1)
            bad = 1;
        model_fault = bad;
        model_y     = '0;
        if (!bad) begin
            r       = apply(plot_pkg::OP_ADD, apply(plot_pkg::OP_DIV, stk[0], SCALE), HALF_VER);
            model_y = r[NUM_W-1:FRAC_W];
        end
    endtask

    // ******************************
    // Port monitor
    // ******************************
    always @(negedge clk) begin
        if (rst) begin
            was_rst     = 1;
            pending     = 0;
            after_start = 0;
            held_y      = '0;
            held_fault  = 0;
        end else begin
            if (was_rst) begin
                checks++;
                if (!ready || done || fault || y_pixel != '0)
                    report("outputs differ from their reset values");
                was_rst = 0;
            end
            if (load_en) begin
                if (pending != 0)
                    report("host wrote the token memory during an evaluation");
                mem[load_addr] = plot_pkg::token_t'(load_token);
            end
            if (after_start) begin
                checks++;
                if (ready)
                    report("ready still high in the cycle after start");
                after_start = 0;
            end
            if (done) begin
                checks++;
                if (!ready)
                    report("ready low in the cycle of done");
                if (pending == 0) begin
                    report("done without an accepted start");
                end else begin
                    if (fault !== model_fault || y_pixel !== model_y)
                        report($sformatf("y_pixel %0d fault %0b, expected y_pixel %0d fault %0b",
                                         y_pixel, fault, model_y, model_fault));
                    if (fault !== table_fault)
                        report($sformatf("fault %0b, table expects %0b", fault, table_fault));
                    pending--;
                end
                held_y     = y_pixel;
                held_fault = fault;
            end else if (y_pixel !== held_y || fault !== held_fault) begin
                report("y_pixel or fault changed without a done");
            end
            if (start && ready) begin
                run_model(x_pixel, int'(expr_len));
                table_fault = exp_fault;
                pending++;
                after_start = 1;
            end
        end
    end

endmodule

// ==== tests/plot_evaluator_tb.sv ====
`timescale 1ns/1ps
`include "plot_macros.svh"

module plot_evaluator_tb;

    localparam int NROWS   = 14;
    localparam int TIMEOUT = 2000;
    localparam logic [`PLOT_TOKEN_W-1:0] Z = '0;  // Unused slot of a table row

    logic                      clk;
    logic                      rst;
    logic                      load_en;
    logic [`PLOT_QUEUE_AW-1:0] load_addr;
    logic [`PLOT_TOKEN_W-1:0]  load_token;
    logic [`PLOT_QUEUE_AW:0]   expr_len;
    logic                      start;
    logic [`PLOT_INT_W-1:0]    x_pixel;
    logic                      exp_fault;
    logic                      ready;
    logic                      done;
    logic                      fault;
    logic [`PLOT_INT_W-1:0]    y_pixel;
    int                        errors;
    int                        checks;
    int                        seed;
    int                        timeouts;

    // ******************************
    // Stimulus table
    // ******************************
    logic [`PLOT_TOKEN_W-1:0] tbl_tok   [NROWS][8];
    int                       tbl_len   [NROWS];
    int                       tbl_x     [NROWS];
    bit                       tbl_rand  [NROWS];  // Column comes from $random
    bit                       tbl_fault [NROWS];

    plot_evaluator plot_evaluator_i (
        .clk        (clk),
        .rst        (rst),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_token (load_token),
        .expr_len   (expr_len),
        .start      (start),
        .x_pixel    (x_pixel),
        .ready      (ready),
        .done       (done),
        .fault      (fault),
        .y_pixel    (y_pixel)
    );

    plot_evaluator_checker checker_i (
        .clk        (clk),
        .rst        (rst),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_token (load_token),
        .expr_len   (expr_len),
        .start      (start),
        .x_pixel    (x_pixel),
        .exp_fault  (exp_fault),
        .ready      (ready),
        .done       (done),
        .fault      (fault),
        .y_pixel    (y_pixel),
        .errors     (errors),
        .checks     (checks)
    );

    // Literal token from a whole number
    function automatic logic [`PLOT_TOKEN_W-1:0] lit(input int v);
        logic [`PLOT_NUM_W-1:0] q;
        q = `PLOT_NUM_W'(v * (1 << `PLOT_FRAC_W));
        return {1'b0, q};
    endfunction

    function automatic logic [`PLOT_TOKEN_W-1:0] opr(input plot_pkg::opcode_e o);
        return {1'b1, {(`PLOT_NUM_W - 3){1'b0}}, o};
    endfunction

    task automatic set_row(input int r, input int len, input int x, input bit rnd,
                           input bit flt);
        tbl_len[r]   = len;
        tbl_x[r]     = x;
        tbl_rand[r]  = rnd;
        tbl_fault[r] = flt;
    endtask

    task automatic build_table();
        logic [`PLOT_TOKEN_W-1:0] ad;
        logic [`PLOT_TOKEN_W-1:0] sb;
        logic [`PLOT_TOKEN_W-1:0] ml;
        logic [`PLOT_TOKEN_W-1:0] dv;
        logic [`PLOT_TOKEN_W-1:0] vx;
        ad = opr(plot_pkg::OP_ADD);
        sb = opr(plot_pkg::OP_SUB);
        ml = opr(plot_pkg::OP_MUL);
        dv = opr(plot_pkg::OP_DIV);
        vx = opr(plot_pkg::OP_VAR_X);
        tbl_tok[0]  = '{lit(3), lit(4), ad, Z, Z, Z, Z, Z};
        set_row(0, 3, 100, 0, 0);
        tbl_tok[1]  = '{vx, Z, Z, Z, Z, Z, Z, Z};
        set_row(1, 1, 0, 0, 0);
        tbl_tok[2]  = '{vx, Z, Z, Z, Z, Z, Z, Z};
        set_row(2, 1, 320, 0, 0);
        tbl_tok[3]  = '{vx, Z, Z, Z, Z, Z, Z, Z};
        set_row(3, 1, 639, 0, 0);
        tbl_tok[4]  = '{vx, Z, Z, Z, Z, Z, Z, Z};
        set_row(4, 1, 0, 1, 0);
        tbl_tok[5]  = '{vx, vx, ml, lit(2), sb, Z, Z, Z};
        set_row(5, 5, 0, 1, 0);
        tbl_tok[6]  = '{lit(5), vx, sb, Z, Z, Z, Z, Z};      // Operand order
        set_row(6, 3, 100, 0, 0);
        tbl_tok[7]  = '{vx, lit(-3), dv, Z, Z, Z, Z, Z};
        set_row(7, 3, 50, 0, 0);
        tbl_tok[8]  = '{lit(-7), vx, ml, lit(3), dv, Z, Z, Z};
        set_row(8, 5, 333, 0, 0);
        tbl_tok[9]  = '{vx, lit(0), dv, Z, Z, Z, Z, Z};
        set_row(9, 3, 10, 0, 1);
        tbl_tok[10] = '{lit(3), ad, Z, Z, Z, Z, Z, Z};
        set_row(10, 2, 200, 0, 1);
        tbl_tok[11] = '{lit(3), lit(4), Z, Z, Z, Z, Z, Z};
        set_row(11, 2, 200, 0, 1);
        tbl_tok[12] = '{vx, lit(3), vx, lit(2), sb, ml, ad, Z};
        set_row(12, 7, 500, 0, 0);
        tbl_tok[13] = '{vx, lit(2), ml, vx, vx, ml, sb, Z};
        set_row(13, 7, 600, 0, 0);
    endtask

    // Loads one row, starts it twice and waits for its done
    task automatic run_row(input int r);
        int i;
        int cnt;
        int x;
        x = tbl_rand[r] ? (($random(seed) & 32'h7fff_ffff) % `PLOT_HOR) : tbl_x[r];
        for (i = 0; i < tbl_len[r]; i++) begin
            @(posedge clk);
            #2;
            load_en    = 1'b1;
            load_addr  = `PLOT_QUEUE_AW'(i);
            load_token = tbl_tok[r][i];
        end
        @(posedge clk);
        #2;
        load_en   = 1'b0;
        expr_len  = (`PLOT_QUEUE_AW + 1)'(tbl_len[r]);
        x_pixel   = `PLOT_INT_W'(x);
        exp_fault = tbl_fault[r];
        start     = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        @(posedge clk);
        #2;
        x_pixel = `PLOT_INT_W'((x + 200) % `PLOT_HOR);  // Ready is low, so ignored
        start   = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        cnt   = 0;
        while (!done && cnt < TIMEOUT) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        if (!done) begin
            $display("Timeout: row %0d hung, no done within %0d cycles", r, TIMEOUT);
            timeouts++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        int r;
        rst        = 1'b1;
        load_en    = 1'b0;
        load_addr  = '0;
        load_token = '0;
        expr_len   = '0;
        start      = 1'b0;
        x_pixel    = '0;
        exp_fault  = 1'b0;
        seed       = 70;
        timeouts   = 0;
        build_table();
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        for (r = 0; r < NROWS && timeouts == 0; r++)
            run_row(r);
        repeat (5) @(posedge clk);
        $display("Rows run: %0d, checks: %0d, errors: %0d, timeouts: %0d",
                 r, checks, errors, timeouts);
        if (errors == 0 && timeouts == 0 && checks > 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// ==== plot_evaluator.f ====
+incdir+design
design/plot_pkg.sv
design/alu_if.sv
design/token_if.sv
design/fixed_point_alu.sv
design/token_queue.sv
design/stack_machine.sv
design/plot_evaluator.sv
tests/plot_evaluator_asserts.sv
tests/plot_evaluator_checker.sv
tests/plot_evaluator_tb.sv

// ==== Bender.yml ====
package:
  name: plot_evaluator

sources:
  - include_dirs:
      - design
    files:
      - design/plot_pkg.sv
      - design/alu_if.sv
      - design/token_if.sv
      - design/fixed_point_alu.sv
      - design/token_queue.sv
      - design/stack_machine.sv
      - design/plot_evaluator.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/plot_evaluator_asserts.sv
      - tests/plot_evaluator_checker.sv
      - tests/plot_evaluator_tb.sv
